/* calc_pkg.sv */
// calc_pkg: operator codes, sign-magnitude word, request structs, width and latency constants
`default_nettype none

package calc_pkg;

    // magnitude width of every operand and result
    localparam int MAG_W = 15;

    // keypad digits above this are not digits
    localparam int DIGIT_MAX = 9;

    // start to finish, in cycles
    localparam int MUL_CYCLES = 16;
    localparam int ADD_CYCLES = 2;

    // NEG toggles the sign of the operand being entered
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    typedef struct packed {
        logic             sign;
        logic [MAG_W-1:0] mag;
    } sm_fields_t;

    // raw view drives the display, fields view feeds the arithmetic
    typedef union packed {
        logic [MAG_W:0] raw;
        sm_fields_t     fields;
    } sm_word_t;

    // entry stage to sequencer
    typedef struct packed {
        op_t      op;
        sm_word_t a;
        sm_word_t b;
    } calc_req_t;

    // sequencer to arithmetic units
    typedef struct packed {
        logic     sub;
        sm_word_t a;
        sm_word_t b;
    } unit_req_t;

endpackage

`default_nettype wire

/* operand_entry.sv */
// operand_entry: keypad digit accumulation, sign toggle and operator capture into a request
`timescale 1ns/1ps
`default_nettype none

module operand_entry import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] keypad_input,
    input  logic       read_input,
    input  op_t        operator_input,
    input  logic       equal_input,
    input  logic       busy,
    input  logic       complete,
    output calc_req_t  req,
    output logic       req_valid
);

    logic     second_phase;
    op_t      op_q;
    sm_word_t opnd_a;
    sm_word_t opnd_b;
    sm_word_t cur_opnd;
    sm_word_t cur_next;
    logic     accept;

    // mag * 10 + digit, wraps at MAG_W bits
    function automatic logic [MAG_W-1:0] shift_add(
        input logic [MAG_W-1:0] mag,
        input logic [3:0]       digit
    );
        logic [MAG_W-1:0] digit_ext;
        digit_ext = {{(MAG_W-4){1'b0}}, digit};
        return (mag << 3) + (mag << 1) + digit_ext;
    endfunction

    // keys dropped from the equal pulse until the result is shown
    assign accept = !busy && !req_valid;

    assign cur_opnd = second_phase ? opnd_b : opnd_a;

    always_comb begin
        cur_next = cur_opnd;
        if (read_input && keypad_input <= DIGIT_MAX) begin
            cur_next.fields.mag = shift_add(cur_opnd.fields.mag, keypad_input);
        end
        if (operator_input == OP_NEG) begin
            cur_next.fields.sign = ~cur_opnd.fields.sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            second_phase <= 1'b0;
            op_q         <= OP_NONE;
            opnd_a       <= '0;
            opnd_b       <= '0;
            req_valid    <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            if (complete) begin
                // result captured, start over with fresh operands
                second_phase <= 1'b0;
                op_q         <= OP_NONE;
                opnd_a       <= '0;
                opnd_b       <= '0;
            end else if (accept) begin
                if (second_phase) begin
                    opnd_b <= cur_next;
                end else begin
                    opnd_a <= cur_next;
                end
                case (operator_input)
                    OP_ADD, OP_SUB, OP_MUL: begin
                        op_q         <= operator_input;
                        second_phase <= 1'b1;
                    end
                    default: begin
                        op_q <= op_q;
                    end
                endcase
                // equal without an operator is ignored
                if (equal_input && second_phase) begin
                    req_valid <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        req.op = op_q;
        req.a  = opnd_a;
        req.b  = opnd_b;
    end

endmodule

`default_nettype wire

/* sm_adder.sv */
// sm_adder: two-stage sign-magnitude add/subtract with start/finish handshake
`timescale 1ns/1ps
`default_nettype none

module sm_adder import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  unit_req_t unit_req,
    input  logic      start,
    output sm_word_t  result,
    output logic      finish
);

    logic             stage_valid;
    logic             b_sign_eff;
    logic             a_sign;
    logic             b_sign;
    logic [MAG_W-1:0] a_mag;
    logic [MAG_W-1:0] b_mag;
    logic             a_ge_b;
    logic             signs_differ;
    logic [MAG_W-1:0] sum_mag;
    logic             sum_sign;

    // subtract is add with b negated
    assign b_sign_eff = unit_req.b.fields.sign ^ unit_req.sub;

    // first stage: operands, magnitude compare, sign difference
    always_ff @(posedge clk) begin
        if (start) begin
            a_sign       <= unit_req.a.fields.sign;
            b_sign       <= b_sign_eff;
            a_mag        <= unit_req.a.fields.mag;
            b_mag        <= unit_req.b.fields.mag;
            a_ge_b       <= unit_req.a.fields.mag >= unit_req.b.fields.mag;
            signs_differ <= unit_req.a.fields.sign ^ b_sign_eff;
        end
    end

    // second stage: larger magnitude decides the sign
    always_comb begin
        if (!signs_differ) begin
            sum_mag  = a_mag + b_mag;
            sum_sign = a_sign;
        end else if (a_ge_b) begin
            sum_mag  = a_mag - b_mag;
            sum_sign = a_sign;
        end else begin
            sum_mag  = b_mag - a_mag;
            sum_sign = b_sign;
        end
        // x + (-x) shows as +0
        if (signs_differ && sum_mag == '0) begin
            sum_sign = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_valid) begin
            result.fields.sign <= sum_sign;
            result.fields.mag  <= sum_mag;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            stage_valid <= 1'b0;
            finish      <= 1'b0;
        end else begin
            stage_valid <= start;
            finish      <= stage_valid;
        end
    end

endmodule

`default_nettype wire

/* sm_multiplier.sv */
// sm_multiplier: sequential shift-and-add sign-magnitude multiplier, one bit per cycle
`timescale 1ns/1ps
`default_nettype none

module sm_multiplier import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  unit_req_t unit_req,
    input  logic      start,
    output sm_word_t  result,
    output logic      finish
);

    logic                            active;
    logic [$clog2(MUL_CYCLES)-1:0]   cycle_cnt;
    logic                            last_cycle;
    logic [MAG_W-1:0]                mcand;
    logic [MAG_W-1:0]                mplier;
    logic [MAG_W-1:0]                acc;
    logic [MAG_W-1:0]                partial;
    logic                            prod_sign;

    assign last_cycle = (cycle_cnt == MUL_CYCLES - 1);
    assign partial    = mplier[0] ? mcand : '0;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            active    <= 1'b0;
            cycle_cnt <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                active    <= 1'b1;
                cycle_cnt <= 1;
            end else if (active) begin
                if (last_cycle) begin
                    active <= 1'b0;
                    finish <= 1'b1;
                end else begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                end
            end
        end
    end

    // product bits above MAG_W fall off, so acc stays MAG_W wide
    always_ff @(posedge clk) begin
        if (start) begin
            // bit 0 partial product is taken in the load cycle
            acc       <= unit_req.b.fields.mag[0] ? unit_req.a.fields.mag : '0;
            mcand     <= unit_req.a.fields.mag << 1;
            mplier    <= unit_req.b.fields.mag >> 1;
            prod_sign <= unit_req.a.fields.sign ^ unit_req.b.fields.sign;
        end else if (active) begin
            if (last_cycle) begin
                // zero product keeps the xor sign
                result.fields.sign <= prod_sign;
                result.fields.mag  <= acc;
            end else begin
                acc    <= acc + partial;
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end
        end
    end

endmodule

`default_nettype wire

/* calc_sequencer.sv */
// calc_sequencer: request dispatch FSM, unit handshake and display capture
`timescale 1ns/1ps
`default_nettype none

module calc_sequencer import calc_pkg::*; (
    input  logic      clk,
    input  logic      nRST,
    input  calc_req_t req,
    input  logic      req_valid,
    input  sm_word_t  add_result,
    input  logic      add_finish,
    input  sm_word_t  mul_result,
    input  logic      mul_finish,
    output unit_req_t unit_req,
    output logic      add_start,
    output logic      mul_start,
    output logic      busy,
    output logic      complete,
    output sm_word_t  display_output
);

    typedef enum logic [1:0] {
        IDLE,
        DISPATCH,
        WAIT_UNIT,
        SHOW
    } seq_state_t;

    seq_state_t state;
    seq_state_t next_state;
    calc_req_t  req_q;
    logic       use_add;
    logic       use_mul;
    logic       unit_finish;
    sm_word_t   unit_result;

    assign use_add = (req_q.op == OP_ADD) || (req_q.op == OP_SUB);
    assign use_mul = (req_q.op == OP_MUL);

    // only the started unit is listened to
    assign unit_finish = use_mul ? mul_finish : add_finish;
    assign unit_result = use_mul ? mul_result : add_result;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req_valid) begin
                    next_state = DISPATCH;
                end
            end
            DISPATCH: begin
                // unknown operator drops the request
                if (use_add || use_mul) begin
                    next_state = WAIT_UNIT;
                end else begin
                    next_state = IDLE;
                end
            end
            WAIT_UNIT: begin
                if (unit_finish) begin
                    next_state = SHOW;
                end
            end
            SHOW: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= IDLE;
            display_output <= '0;
        end else begin
            state <= next_state;
            if (state == WAIT_UNIT && unit_finish) begin
                display_output <= unit_result;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            req_q <= req;
        end
    end

    always_comb begin
        unit_req.sub = (req_q.op == OP_SUB);
        unit_req.a   = req_q.a;
        unit_req.b   = req_q.b;
    end

    // one-cycle starts, both units share unit_req
    assign add_start = (state == DISPATCH) && use_add;
    assign mul_start = (state == DISPATCH) && use_mul;

    // busy already low while complete is shown
    assign busy     = (state == DISPATCH) || (state == WAIT_UNIT);
    assign complete = (state == SHOW);

endmodule

`default_nettype wire

/* calc_top.sv */
// calc_top: keypad calculator core with entry stage, sequencer, adder and multiplier
`timescale 1ns/1ps
`default_nettype none

module calc_top import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] keypad_input,
    input  logic       read_input,
    input  op_t        operator_input,
    input  logic       equal_input,
    output logic       complete,
    output sm_word_t   display_output,
    output logic       busy
);

    calc_req_t req;
    logic      req_valid;
    unit_req_t unit_req;
    logic      add_start;
    logic      mul_start;
    sm_word_t  add_result;
    logic      add_finish;
    sm_word_t  mul_result;
    logic      mul_finish;

    operand_entry entry_stage (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .req            (req),
        .req_valid      (req_valid)
    );

    calc_sequencer sequencer (
        .clk            (clk),
        .nRST           (nRST),
        .req            (req),
        .req_valid      (req_valid),
        .add_result     (add_result),
        .add_finish     (add_finish),
        .mul_result     (mul_result),
        .mul_finish     (mul_finish),
        .unit_req       (unit_req),
        .add_start      (add_start),
        .mul_start      (mul_start),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output)
    );

    sm_adder adder (
        .clk      (clk),
        .nRST     (nRST),
        .unit_req (unit_req),
        .start    (add_start),
        .result   (add_result),
        .finish   (add_finish)
    );

    sm_multiplier multiplier (
        .clk      (clk),
        .nRST     (nRST),
        .unit_req (unit_req),
        .start    (mul_start),
        .result   (mul_result),
        .finish   (mul_finish)
    );

endmodule

`default_nettype wire

/* calc_tb.sv */
// calc_tb: self-checking testbench for calc_top with file-driven and xorshift random tests
`timescale 1ns/1ps
`default_nettype none

module calc_tb import calc_pkg::*; ();

    localparam int RANDOM_TESTS = 20;
    // digit and operator pulses in the longest random test
    localparam int RANDOM_MAX_KEYS = 13;

    logic       clk;
    logic       nRST;
    logic [3:0] keypad_input;
    logic       read_input;
    op_t        operator_input;
    logic       equal_input;
    logic       complete;
    sm_word_t   display_output;
    logic       busy;

    // stimulus file, one entry per command
    logic [7:0] cmd_q[$];
    int         arg_q[$];
    int         file_tests;
    int         file_max_keys;

    // reference model of the entry stage
    logic [15:0] m_a;
    logic [15:0] m_b;
    bit          m_second;
    int          m_op;
    logic [15:0] last_expected;

    logic [31:0] rng;
    int          error_count;
    int          test_count;
    int          pass_count;
    int          test_start_errors;
    int          cycle_count;
    int          cycle_limit;

    calc_top calc_top_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output),
        .busy           (busy)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int random_below(input int bound);
        rng = xorshift32(rng);
        return int'(rng % 32'(bound));
    endfunction

    // mag * 10 + digit, wrapped to 15 bits
    function automatic logic [15:0] entry_digit(input logic [15:0] w, input int digit);
        int mag;
        mag = (int'(w[14:0]) * 10 + digit) % 32768;
        return {w[15], mag[14:0]};
    endfunction

    function automatic logic [15:0] rule_result(input int op, input logic [15:0] a,
                                                input logic [15:0] b);
        logic sa;
        logic sb;
        logic sign;
        int   ma;
        int   mb;
        int   mag;
        sa = a[15];
        sb = b[15];
        ma = int'(a[14:0]);
        mb = int'(b[14:0]);
        if (op == 4) begin
            sign = sa ^ sb;
            mag  = (ma * mb) % 32768;
        end else begin
            if (op == 3) begin
                sb = ~sb;
            end
            if (sa == sb) begin
                sign = sa;
                mag  = (ma + mb) % 32768;
            end else if (ma == mb) begin
                sign = 1'b0;
                mag  = 0;
            end else if (ma > mb) begin
                sign = sa;
                mag  = ma - mb;
            end else begin
                sign = sb;
                mag  = mb - ma;
            end
        end
        return {sign, mag[14:0]};
    endfunction

    task automatic drive_inputs(input logic [3:0] key, input logic rd, input logic [2:0] op,
                                input logic eq);
        keypad_input   = key;
        read_input     = rd;
        operator_input = op_t'(op);
        equal_input    = eq;
    endtask

    // pulses that must all be dropped while busy
    task automatic drive_noise(input int n);
        case (n % 3)
            0:       drive_inputs(4'd7, 1'b1, 3'd0, 1'b0);
            1:       drive_inputs(4'd0, 1'b0, 3'd1, 1'b0);
            default: drive_inputs(4'd3, 1'b1, 3'd2, 1'b1);
        endcase
    endtask

    task automatic key_pulse(input int digit);
        @(posedge clk);
        #2;
        drive_inputs(4'(digit), 1'b1, 3'd0, 1'b0);
        @(posedge clk);
        #2;
        drive_inputs(4'd0, 1'b0, 3'd0, 1'b0);
        if (digit <= DIGIT_MAX) begin
            if (m_second) begin
                m_b = entry_digit(m_b, digit);
            end else begin
                m_a = entry_digit(m_a, digit);
            end
        end
    endtask

    task automatic operator_pulse(input int code);
        @(posedge clk);
        #2;
        drive_inputs(4'd0, 1'b0, 3'(code), 1'b0);
        @(posedge clk);
        #2;
        drive_inputs(4'd0, 1'b0, 3'd0, 1'b0);
        if (code == 1 && m_second) begin
            m_b[15] = ~m_b[15];
        end else if (code == 1) begin
            m_a[15] = ~m_a[15];
        end else if (code >= 2 && code <= 4) begin
            m_op     = code;
            m_second = 1'b1;
        end
    endtask

    task automatic equal_and_check(input bit noise);
        logic [15:0] expected;
        logic        expected_busy;
        int          want;
        int          limit;
        int          n;
        bit          seen;
        expected = rule_result(m_op, m_a, m_b);
        want     = (m_op == 4) ? 19 : 5;
        limit    = m_second ? want + 10 : 25;
        @(posedge clk);
        #2;
        drive_inputs(4'd0, 1'b0, 3'd0, 1'b1);
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(posedge clk);
            n++;
            #2;
            if (noise) begin
                drive_noise(n);
            end else begin
                drive_inputs(4'd0, 1'b0, 3'd0, 1'b0);
            end
            @(negedge clk);
            // high from the cycle after the request until the result shows
            expected_busy = m_second && n >= 2 && n < want;
            if (busy !== expected_busy) begin
                $display("mismatch busy: got %h, expected %h, %0d cycles after equal",
                         busy, expected_busy, n);
                error_count++;
            end
            if (complete) begin
                seen = 1'b1;
            end
        end
        if (m_second) begin
            if (!seen) begin
                $display("no complete arrived within %0d cycles of equal", limit);
                error_count++;
            end else begin
                if (n != want) begin
                    $display("complete came %0d cycles after equal, expected %0d", n, want);
                    error_count++;
                end
                if (display_output.raw !== expected) begin
                    $display("mismatch display_output: got %h, expected %h",
                             display_output.raw, expected);
                    error_count++;
                end
            end
            last_expected = expected;
            m_a      = '0;
            m_b      = '0;
            m_second = 1'b0;
            m_op     = 0;
        end else if (seen) begin
            $display("complete appeared after an equal with no operator chosen");
            error_count++;
        end
    endtask

    task automatic load_stimulus();
        int                 fd;
        int                 code;
        int                 arg;
        int                 keys;
        logic [63:0]        word;
        logic [8*128-1:0]   line;
        keys = 0;
        fd   = $fopen("calc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open calc_stimulus.txt");
            error_count++;
            return;
        end
        while ($fscanf(fd, "%s", word) == 1) begin
            if (word == "#") begin
                code = $fgets(line, fd);
            end else if (word == "E") begin
                cmd_q.push_back("E");
                arg_q.push_back(0);
            end else if (word == "K" || word == "O" || word == "X") begin
                code = $fscanf(fd, "%h", arg);
                if (code != 1) begin
                    $display("calc_stimulus.txt has a command without its value");
                    error_count++;
                end
                cmd_q.push_back(word[7:0]);
                arg_q.push_back(arg);
                if (word == "X") begin
                    file_tests++;
                    file_max_keys = (keys > file_max_keys) ? keys : file_max_keys;
                    keys = 0;
                end else begin
                    keys++;
                end
            end else begin
                $display("unknown command in calc_stimulus.txt");
                error_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_random_test(input int index);
        int n_digits;
        n_digits = 1 + random_below(5);
        repeat (n_digits) key_pulse(random_below(10));
        if (random_below(2) == 1) begin
            operator_pulse(1);
        end
        operator_pulse(2 + index % 3);
        n_digits = 1 + random_below(5);
        repeat (n_digits) key_pulse(random_below(10));
        if (random_below(2) == 1) begin
            operator_pulse(1);
        end
        // every random calculation also sees key pulses while busy
        equal_and_check(1'b1);
    endtask

    task automatic end_test(input string label);
        test_count++;
        if (error_count == test_start_errors) begin
            pass_count++;
            $display("test %0d (%s) passed", test_count, label);
        end else begin
            $display("test %0d (%s) failed", test_count, label);
        end
        test_start_errors = error_count;
    endtask

    initial begin
        int          i;
        int          max_keys;
        logic [15:0] file_value;
        clk = 1'b0;
        nRST = 1'b0;
        drive_inputs(4'd0, 1'b0, 3'd0, 1'b0);
        m_a = '0;
        m_b = '0;
        m_second = 1'b0;
        m_op = 0;
        last_expected = '0;
        rng = 32'h6c27;
        error_count = 0;
        test_count = 0;
        pass_count = 0;
        test_start_errors = 0;
        file_tests = 0;
        file_max_keys = 0;
        cycle_count = 0;
        cycle_limit = 0;
        load_stimulus();
        test_start_errors = error_count;
        max_keys = (file_max_keys > RANDOM_MAX_KEYS) ? file_max_keys : RANDOM_MAX_KEYS;
        cycle_limit = (file_tests + RANDOM_TESTS)
                    * (max_keys * 2 + 2 * (MUL_CYCLES + ADD_CYCLES) + 4) + 8;
        repeat (4) @(posedge clk);
        #2;
        nRST = 1'b1;
        for (i = 0; i < cmd_q.size(); i++) begin
            case (cmd_q[i])
                "K": key_pulse(arg_q[i]);
                "O": operator_pulse(arg_q[i]);
                "E": equal_and_check(1'b0);
                "X": begin
                    file_value = arg_q[i][15:0];
                    if (file_value !== last_expected) begin
                        $display("mismatch stimulus expected value: file %h, predicted %h",
                                 file_value, last_expected);
                        error_count++;
                    end
                    if (display_output.raw !== file_value) begin
                        $display("mismatch display_output: got %h, expected %h",
                                 display_output.raw, file_value);
                        error_count++;
                    end
                    end_test("file");
                end
                default: begin
                end
            endcase
        end
        for (i = 0; i < RANDOM_TESTS; i++) begin
            run_random_test(i);
            end_test("random");
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_count, pass_count, test_count - pass_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* calc_top.f */
calc_pkg.sv
operand_entry.sv
sm_adder.sv
sm_multiplier.sv
calc_sequencer.sv
calc_top.sv
calc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build calc_tb with Verilator, run it, and decide the result from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module calc_tb -f calc_top.f -o calc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/calc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

/* calc_stimulus.txt */
# K d = digit key (hex), O n = operator code, E = equal key
# X h = expected display value (hex), which ends a test
K 4
K 7
O 2
K 8
E
X 0037

K 2
K 5
O 3
K 7
K 0
E
X 802d

K 5
O 2
O 1
K 5
E
X 0000

K 1
K 2
O 4
K 1
K 1
O 1
E
X 8084

K 3
K 0
K 0
O 1
O 4
K 2
K 0
K 0
O 1
E
X 6a60

K 0
O 1
O 4
K 9
E
X 8000

K 1
K c
O 5
E
K 2
O 2
K f
O 7
K 3
E
X 000f
